//--- design/rx_pkg.sv
// shared widths, register map and line FSM states for the capture front end
// referenced by scoped name from every RTL block

package rx_pkg;

    // ==================================================
    // coordinate and buffer widths
    // ==================================================
    localparam int COORD_W    = 10;   // row / column / width counters
    localparam int BUF_ADDR_W = 10;   // one line-buffer bank

    typedef logic [COORD_W-1:0]    coord_t;
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    // ==================================================
    // wishbone register map
    // ==================================================
    localparam int WB_ADR_W = 3;      // word address
    localparam int WB_DAT_W = 16;     // wide enough for any bound

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_data_t;

    localparam wb_adr_t REG_ROW_START = 3'd0;  // first window row
    localparam wb_adr_t REG_ROW_END   = 3'd1;  // last window row
    localparam wb_adr_t REG_COL_START = 3'd2;  // first window column
    localparam wb_adr_t REG_COL_END   = 3'd3;  // last window column, clamped
    localparam wb_adr_t REG_REVERSE   = 3'd4;  // bit 0 only

    // ==================================================
    // line tracking states, one-hot
    // ==================================================
    typedef enum logic [2:0] {
        IDLE = 3'b001,   // waiting for a frame
        REC  = 3'b010,   // inside an active line
        NXT  = 3'b100    // between lines of a frame
    } line_state_t;

endpackage

//--- design/rx_cfg_regs.sv
// capture window configuration, reached over a Wishbone classic slave
// one-cycle ack, re-armed only after stb has been seen low

module rx_cfg_regs #(
    parameter int LINE_DEPTH = 640
) (
    input  logic             ch_clk,
    input  logic             reset,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  rx_pkg::wb_adr_t  wb_adr,
    input  rx_pkg::wb_data_t wb_dat_i,
    output rx_pkg::wb_data_t wb_dat_o,
    output logic             wb_ack,
    output rx_pkg::coord_t   row_start,
    output rx_pkg::coord_t   row_end,
    output rx_pkg::coord_t   col_start,
    output rx_pkg::coord_t   col_end,
    output logic             reverse
);

    // last column that still fits in one bank
    localparam rx_pkg::wb_data_t DEPTH_LIMIT = rx_pkg::wb_data_t'(LINE_DEPTH - 1);

    logic             ack_armed;   // cleared by an ack, set again when stb drops
    logic             access;
    rx_pkg::wb_data_t rd_data;

    assign access = wb_cyc && wb_stb && ack_armed;

    // read mux, unmapped offsets give zero
    always_comb begin
        rd_data = '0;
        case (wb_adr)
            rx_pkg::REG_ROW_START: rd_data = rx_pkg::wb_data_t'(row_start);
            rx_pkg::REG_ROW_END:   rd_data = rx_pkg::wb_data_t'(row_end);
            rx_pkg::REG_COL_START: rd_data = rx_pkg::wb_data_t'(col_start);
            rx_pkg::REG_COL_END:   rd_data = rx_pkg::wb_data_t'(col_end);
            rx_pkg::REG_REVERSE:   rd_data = rx_pkg::wb_data_t'(reverse);
            default:               rd_data = '0;
        endcase
    end

    // ==================================================
    // handshake and register writes
    // ==================================================
    always_ff @(posedge ch_clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            ack_armed <= 1'b1;
            row_start <= '0;
            row_end   <= '0;
            col_start <= '0;
            col_end   <= '0;
            reverse   <= 1'b0;
        end else begin
            wb_ack <= access;
            if (access) begin
                ack_armed <= 1'b0;
            end else if (!wb_stb) begin
                ack_armed <= 1'b1;   // master let go, next cycle may start
            end
            if (access && wb_we) begin
                case (wb_adr)
                    rx_pkg::REG_ROW_START: row_start <= rx_pkg::coord_t'(wb_dat_i);
                    rx_pkg::REG_ROW_END:   row_end   <= rx_pkg::coord_t'(wb_dat_i);
                    rx_pkg::REG_COL_START: col_start <= rx_pkg::coord_t'(wb_dat_i);
                    rx_pkg::REG_COL_END: begin
                        // window must never run past the end of a bank
                        col_end <= (wb_dat_i > DEPTH_LIMIT) ?
                                   rx_pkg::coord_t'(DEPTH_LIMIT) :
                                   rx_pkg::coord_t'(wb_dat_i);
                    end
                    rx_pkg::REG_REVERSE:   reverse   <= wb_dat_i[0];
                    default: ;                           // ignored, still acked
                endcase
            end
        end
    end

    // read data lands together with ack
    always_ff @(posedge ch_clk) begin
        if (access) begin
            wb_dat_o <= rd_data;
        end
    end

    a_single_ack: assert property (@(posedge ch_clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held high for two cycles");

endmodule

//--- design/line_tracker.sv
// follows active_video / vblank on accepted cycles (ce high)
// gives each pixel its column and row one accepted cycle later, and measures line width

module line_tracker (
    input  logic                ch_clk,
    input  logic                reset,
    input  logic                ce,
    input  logic                active_video,
    input  logic                vblank,
    output logic                pix_valid,
    output rx_pkg::coord_t      col,
    output rx_pkg::coord_t      row,
    output rx_pkg::line_state_t line_state,
    output logic                line_end,
    output logic                frame_end,
    output rx_pkg::coord_t      line_width
);

    logic                active_d;     // last accepted sample of active_video
    rx_pkg::line_state_t next_state;

    // ==================================================
    // input events
    // ==================================================
    // falling edge of active_video, seen on an accepted cycle
    assign line_end = ce && active_d && !active_video;

    // vblank outside of a line closes the frame
    assign frame_end = ce && vblank && !active_video && (line_state != rx_pkg::REC);

    always_ff @(posedge ch_clk) begin
        if (reset) begin
            active_d <= 1'b0;
        end else if (ce) begin
            active_d <= active_video;
        end
    end

    // ==================================================
    // line state machine
    // ==================================================
    always_comb begin
        next_state = line_state;
        case (line_state)
            rx_pkg::IDLE: begin
                if (active_video) begin
                    next_state = rx_pkg::REC;   // first line of a frame
                end
            end
            rx_pkg::REC: begin
                if (!active_video) begin
                    next_state = rx_pkg::NXT;
                end
            end
            rx_pkg::NXT: begin
                if (active_video) begin
                    next_state = rx_pkg::REC;
                end else if (vblank) begin
                    next_state = rx_pkg::IDLE;  // frame done
                end
            end
            default: next_state = rx_pkg::IDLE;
        endcase
    end

    always_ff @(posedge ch_clk) begin
        if (reset) begin
            line_state <= rx_pkg::IDLE;
        end else if (ce) begin
            line_state <= next_state;
        end
    end

    // ==================================================
    // pixel coordinates and width
    // ==================================================
    always_ff @(posedge ch_clk) begin
        if (reset) begin
            pix_valid  <= 1'b0;
            col        <= '0;
            row        <= '0;
            line_width <= '0;
        end else if (ce) begin
            pix_valid <= active_video;
            if (active_video) begin
                col <= active_d ? col + 1'b1 : '0;   // restart on a new line
            end
            // col still holds the last pixel of the line here
            if (line_end) begin
                row        <= row + 1'b1;
                line_width <= col + 1'b1;
            end else if (frame_end) begin
                row <= '0;
            end
        end
    end

    // row only moves on the edge that leaves a line
    a_row_steady: assert property (@(posedge ch_clk) disable iff (reset)
        (line_state == rx_pkg::REC) |=> (line_state != rx_pkg::REC || $stable(row)))
        else $error("row changed inside an active line");

endmodule

//--- design/window_gate.sv
// capture window test for each pixel, one accepted cycle after line_tracker
// also flags finished window rows and the first window pixel of a frame

module window_gate (
    input  logic                ch_clk,
    input  logic                reset,
    input  logic                ce,
    input  logic                pix_valid,
    input  rx_pkg::coord_t      col,
    input  rx_pkg::coord_t      row,
    input  rx_pkg::line_state_t line_state,
    input  logic                line_end,
    input  rx_pkg::coord_t      row_start,
    input  rx_pkg::coord_t      row_end,
    input  rx_pkg::coord_t      col_start,
    input  rx_pkg::coord_t      col_end,
    output logic                in_win,
    output logic                win_row_done,
    output logic                frame_start
);

    logic row_hit;
    logic col_hit;
    logic pix_hit;
    logic fs_armed;   // one frame_start allowed per frame
    logic fs_q;

    assign row_hit = (row >= row_start) && (row <= row_end);
    assign col_hit = (col >= col_start) && (col <= col_end);
    assign pix_hit = pix_valid && row_hit && col_hit;

    always_ff @(posedge ch_clk) begin
        if (reset) begin
            in_win       <= 1'b0;
            win_row_done <= 1'b0;
            fs_armed     <= 1'b1;
            fs_q         <= 1'b0;
        end else if (ce) begin
            in_win       <= pix_hit;
            win_row_done <= line_end && row_hit;   // row not yet advanced
            if (pix_hit && fs_armed) begin
                fs_q     <= 1'b1;
                fs_armed <= 1'b0;
            end else begin
                fs_q <= 1'b0;
                if (line_state == rx_pkg::IDLE) begin
                    fs_armed <= 1'b1;               // between frames
                end
            end
        end
    end

    // one strobe per frame even across ce holes
    assign frame_start = fs_q && ce;

endmodule

//--- design/pingpong_addr.sv
// write side of the ping-pong line buffers
// bank select plus a forward or reverse address pointer, stepped per window pixel

module pingpong_addr #(
    parameter int LINE_DEPTH = 640
) (
    input  logic              ch_clk,
    input  logic              reset,
    input  logic              ce,
    input  logic              in_win,
    input  logic              win_row_done,
    input  logic              frame_end,
    input  rx_pkg::coord_t    col_start,
    input  rx_pkg::coord_t    col_end,
    input  logic              reverse,
    output logic              wr_en,
    output logic              wr_bank,
    output rx_pkg::buf_addr_t wr_addr
);

    rx_pkg::buf_addr_t start_addr;

    // reverse lines fill from the far end of the window down to 0
    assign start_addr = reverse ? rx_pkg::buf_addr_t'(col_end - col_start) : '0;

    // one write per accepted pixel
    assign wr_en = in_win && ce;

    // ==================================================
    // bank select
    // ==================================================
    always_ff @(posedge ch_clk) begin
        if (reset) begin
            wr_bank <= 1'b1;
        end else if (ce) begin
            if (frame_end) begin
                wr_bank <= 1'b1;          // every frame starts in bank 1
            end else if (win_row_done) begin
                wr_bank <= ~wr_bank;      // after the row's last write
            end
        end
    end

    // ==================================================
    // address pointer
    // ==================================================
    // wr_addr always holds the address of the pixel now on in_win.
    // Outside the window it sits on the start address of the next line
    always_ff @(posedge ch_clk) begin
        if (reset) begin
            wr_addr <= '0;
        end else if (ce) begin
            if (!in_win) begin
                wr_addr <= start_addr;
            end else if (reverse) begin
                wr_addr <= wr_addr - 1'b1;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // col_end clamp in the register block keeps every write inside a bank
    a_addr_in_bank: assert property (@(posedge ch_clk) disable iff (reset)
        wr_en |-> (int'(wr_addr) < LINE_DEPTH))
        else $error("write address %0d beyond bank depth", wr_addr);

endmodule

//--- design/video_rx_top.sv
// receive-side timing front end of one video capture channel
// Wishbone configured window, ping-pong line-buffer write strobes and addresses out

module video_rx_top #(
    parameter int LINE_DEPTH = 640
) (
    input  logic              ch_clk,
    input  logic              reset,
    // wishbone slave
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  rx_pkg::wb_adr_t   wb_adr,
    input  rx_pkg::wb_data_t  wb_dat_i,
    output rx_pkg::wb_data_t  wb_dat_o,
    output logic              wb_ack,
    // video in
    input  logic              ce,
    input  logic              active_video,
    input  logic              vblank,
    // line buffer write side
    output logic              wr_en,
    output logic              wr_bank,
    output rx_pkg::buf_addr_t wr_addr,
    output logic              frame_start,
    output rx_pkg::coord_t    line_width
);

    // ==================================================
    // internal wiring
    // ==================================================
    rx_pkg::coord_t      row_start;
    rx_pkg::coord_t      row_end;
    rx_pkg::coord_t      col_start;
    rx_pkg::coord_t      col_end;
    logic                reverse;

    logic                pix_valid;
    rx_pkg::coord_t      col;
    rx_pkg::coord_t      row;
    rx_pkg::line_state_t line_state;
    logic                line_end;
    logic                frame_end;

    logic                in_win;
    logic                win_row_done;

    rx_cfg_regs #(.LINE_DEPTH(LINE_DEPTH)) u_cfg (
        .ch_clk(ch_clk), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .row_start(row_start), .row_end(row_end),
        .col_start(col_start), .col_end(col_end), .reverse(reverse)
    );

    line_tracker u_track (
        .ch_clk(ch_clk), .reset(reset), .ce(ce),
        .active_video(active_video), .vblank(vblank),
        .pix_valid(pix_valid), .col(col), .row(row), .line_state(line_state),
        .line_end(line_end), .frame_end(frame_end), .line_width(line_width)
    );

    window_gate u_win (
        .ch_clk(ch_clk), .reset(reset), .ce(ce),
        .pix_valid(pix_valid), .col(col), .row(row),
        .line_state(line_state), .line_end(line_end),
        .row_start(row_start), .row_end(row_end),
        .col_start(col_start), .col_end(col_end),
        .in_win(in_win), .win_row_done(win_row_done), .frame_start(frame_start)
    );

    pingpong_addr #(.LINE_DEPTH(LINE_DEPTH)) u_wr (
        .ch_clk(ch_clk), .reset(reset), .ce(ce),
        .in_win(in_win), .win_row_done(win_row_done), .frame_end(frame_end),
        .col_start(col_start), .col_end(col_end), .reverse(reverse),
        .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr)
    );

endmodule

//--- bench/rx_checker.sv
// watches the capture front end and compares its write side with a reference model
// expected values come from the pixel tags that the stimulus drives next to the video

module rx_checker (
    input  logic              ch_clk,
    input  logic              reset,
    input  logic              ce,
    input  logic              active_video,
    input  logic              wr_en,
    input  logic              wr_bank,
    input  rx_pkg::buf_addr_t wr_addr,
    input  logic              frame_start,
    input  rx_pkg::coord_t    line_width,
    input  int                pix_col,
    input  int                pix_row,
    input  int                pix_frame,
    input  int                cfg_row_start,
    input  int                cfg_row_end,
    input  int                cfg_col_start,
    input  int                cfg_col_end,
    input  logic              cfg_reverse,
    output int                mismatches,
    output int                writes_checked
);

    // one entry per accepted cycle, popped two accepted cycles later
    logic q_en[$];
    logic q_bank[$];
    int   q_addr[$];
    int   q_frame[$];

    int   last_fs_frame;   // frame that already had its frame_start
    int   line_cnt;
    int   exp_width;
    logic act_d;

    function automatic void expect_write(input int col, input int row, output logic en,
                                         output logic bank, output int addr);
        en   = (row >= cfg_row_start) && (row <= cfg_row_end) &&
               (col >= cfg_col_start) && (col <= cfg_col_end);
        bank = ((row - cfg_row_start) % 2) == 0;   // first window row goes to bank 1
        addr = cfg_reverse ? cfg_col_end - col : col - cfg_col_start;
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            mismatches++;
        end
    endtask

    // ==================================================
    // compare on the falling edge, inputs and outputs settled
    // ==================================================
    always @(negedge ch_clk) begin
        logic e_en;
        logic e_bank;
        int   e_addr;
        int   e_frame;
        logic n_en;
        logic n_bank;
        int   n_addr;
        if (reset) begin
            q_en.delete();
            q_bank.delete();
            q_addr.delete();
            q_frame.delete();
            last_fs_frame = -1;
            line_cnt      = 0;
            exp_width     = 0;
            act_d         = 1'b0;
        end else begin
            check_value("line_width", int'(line_width), exp_width);
            e_en    = 1'b0;
            e_bank  = 1'b0;
            e_addr  = 0;
            e_frame = 0;
            if (ce && q_en.size() == 2) begin
                e_en    = q_en.pop_front();
                e_bank  = q_bank.pop_front();
                e_addr  = q_addr.pop_front();
                e_frame = q_frame.pop_front();
            end
            check_value("wr_en", int'(wr_en), int'(e_en));
            check_value("frame_start", int'(frame_start),
                        int'(e_en && (e_frame != last_fs_frame)));
            if (e_en) begin
                last_fs_frame = e_frame;
                check_value("wr_bank", int'(wr_bank), int'(e_bank));
                check_value("wr_addr", int'(wr_addr), e_addr);
                writes_checked++;
            end
            if (ce) begin
                expect_write(pix_col, pix_row, n_en, n_bank, n_addr);
                q_en.push_back(active_video && n_en);
                q_bank.push_back(n_bank);
                q_addr.push_back(n_addr);
                q_frame.push_back(pix_frame);
                if (active_video) begin
                    line_cnt++;
                end else if (act_d) begin   // line just closed
                    exp_width = line_cnt;
                    line_cnt  = 0;
                end
                act_d = active_video;
            end
        end
    end

endmodule

//--- bench/tb_video_rx.sv
// top-level testbench for the video capture front end
// sets the window over Wishbone, streams random frames and prints the final status

module tb_video_rx;

    localparam int LINE_DEPTH  = 64;   // small banks, col_end clamp easy to reach
    localparam int ACK_TIMEOUT = 16;

    logic              ch_clk = 1'b0;
    logic              reset;
    logic              wb_cyc, wb_stb, wb_we, wb_ack;
    rx_pkg::wb_adr_t   wb_adr;
    rx_pkg::wb_data_t  wb_dat_i, wb_dat_o;
    logic              ce, active_video, vblank;
    logic              wr_en, wr_bank, frame_start;
    rx_pkg::buf_addr_t wr_addr;
    rx_pkg::coord_t    line_width;

    int   pix_col, pix_row, pix_frame;   // tags of the pixel on the inputs
    int   cfg_row_start, cfg_row_end, cfg_col_start, cfg_col_end;
    logic cfg_reverse;
    int   mismatches, writes_checked;
    int   bus_errors, timeouts;
    int   seed = 75763;
    int   hole_mask;                     // 0 means no ce holes

    always #4 ch_clk = ~ch_clk;

    video_rx_top #(.LINE_DEPTH(LINE_DEPTH)) UUT (.*);
    rx_checker chk (.*);

    // ==================================================
    // wishbone master
    // ==================================================
    task automatic wb_access(input logic we, input rx_pkg::wb_adr_t adr,
                             input rx_pkg::wb_data_t wdata, output rx_pkg::wb_data_t rdata);
        int   n;
        logic got_ack;
        @(posedge ch_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdata;
        n       = 0;
        got_ack = 1'b0;
        rdata   = '0;
        while (!got_ack && n < ACK_TIMEOUT) begin
            @(negedge ch_clk);
            got_ack = wb_ack;
            rdata   = wb_dat_o;
            n++;
        end
        if (!got_ack) begin
            $display("Timeout: register %0d gave no ack in %0d cycles", adr, ACK_TIMEOUT);
            timeouts++;
        end
        @(posedge ch_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge ch_clk);
        if (wb_ack) begin
            $display("Register %0d was acked a second time", adr);
            bus_errors++;
        end
    endtask

    task automatic reg_write(input rx_pkg::wb_adr_t adr, input int value);
        rx_pkg::wb_data_t ignored;
        wb_access(1'b1, adr, rx_pkg::wb_data_t'(value), ignored);
    endtask

    task automatic reg_check(input rx_pkg::wb_adr_t adr, input int expected);
        rx_pkg::wb_data_t got;
        wb_access(1'b0, adr, '0, got);
        if (int'(got) != expected) begin
            $display("Mismatch wb_dat_o at register %0d: got 0x%0h expected 0x%0h",
                     adr, got, expected);
            bus_errors++;
        end
    endtask

    // program the window, read it all back
    task automatic set_window(input int rs, input int re, input int cs, input int cl,
                              input logic rev);
        int cl_stored;
        cl_stored = (cl > LINE_DEPTH - 1) ? LINE_DEPTH - 1 : cl;   // bank depth clamp
        reg_write(rx_pkg::REG_ROW_START, rs);
        reg_write(rx_pkg::REG_ROW_END, re);
        reg_write(rx_pkg::REG_COL_START, cs);
        reg_write(rx_pkg::REG_COL_END, cl);
        reg_write(rx_pkg::REG_REVERSE, int'(rev));
        reg_check(rx_pkg::REG_ROW_START, rs);
        reg_check(rx_pkg::REG_ROW_END, re);
        reg_check(rx_pkg::REG_COL_START, cs);
        reg_check(rx_pkg::REG_COL_END, cl_stored);
        reg_check(rx_pkg::REG_REVERSE, int'(rev));
        cfg_row_start <= rs;
        cfg_row_end   <= re;
        cfg_col_start <= cs;
        cfg_col_end   <= cl_stored;
        cfg_reverse   <= rev;
    endtask

    // ==================================================
    // video stimulus
    // ==================================================
    task automatic drive_sample(input logic act, input logic vb, input int col, input int row);
        while (($random(seed) & hole_mask) == 1) begin
            @(posedge ch_clk);
            ce           <= 1'b0;
            active_video <= ($random(seed) & 1) != 0;   // junk, must not be sampled
            vblank       <= ($random(seed) & 1) != 0;
        end
        @(posedge ch_clk);
        ce           <= 1'b1;
        active_video <= act;
        vblank       <= vb;
        pix_col      <= col;
        pix_row      <= row;
    endtask

    task automatic drive_frame(input int lines);
        int width;
        for (int r = 0; r < lines; r++) begin
            width = 12 + ($random(seed) & 31);
            for (int c = 0; c < width; c++) drive_sample(1'b1, 1'b0, c, r);
            repeat (1 + ($random(seed) & 3)) drive_sample(1'b0, 1'b0, 0, 0);   // h gap
        end
        repeat (4) drive_sample(1'b0, 1'b1, 0, 0);
        drive_sample(1'b0, 1'b0, 0, 0);
        pix_frame <= pix_frame + 1;
    endtask

    initial begin
        reset        = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_i     = '0;
        ce           = 1'b0;
        active_video = 1'b0;
        vblank       = 1'b0;
        pix_col      = 0;
        pix_row      = 0;
        pix_frame    = 0;
        cfg_row_start = 0;
        cfg_row_end   = 0;
        cfg_col_start = 0;
        cfg_col_end   = 0;
        cfg_reverse   = 1'b0;
        hole_mask     = 0;
        repeat (10) @(posedge ch_clk);
        reset <= 1'b0;

        for (int a = 0; a < 5; a++) reg_check(rx_pkg::wb_adr_t'(a), 0);   // reset values
        reg_write(3'd6, 'h1234);   // unmapped, acked and dropped
        reg_check(3'd6, 0);

        set_window(2, 5, 4, 20, 1'b0);
        repeat (2) drive_frame(8);
        set_window(0, 3, 10, 30, 1'b1);
        repeat (2) drive_frame(6);

        // same again with ce holes
        hole_mask = 3;
        set_window(1, 6, 8, 100, 1'b0);
        repeat (2) drive_frame(8);
        set_window(3, 3, 0, 40, 1'b1);
        repeat (2) drive_frame(5);
        repeat (8) drive_sample(1'b0, 1'b0, 0, 0);

        if (writes_checked == 0) begin
            $display("No window writes were seen during the run");
            bus_errors++;
        end
        $display("errors: mismatches %0d, bus %0d, timeouts %0d",
                 mismatches, bus_errors, timeouts);
        if (mismatches + bus_errors + timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
design/rx_pkg.sv
design/rx_cfg_regs.sv
design/line_tracker.sv
design/window_gate.sv
design/pingpong_addr.sv
design/video_rx_top.sv
bench/rx_checker.sv
bench/tb_video_rx.sv

//--- Makefile
# Verilator flow for the video capture front end

TOP := tb_video_rx

.PHONY: lint sim clean

lint:
	verilator --lint-only -sv --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary -sv --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log
